// File: bench/data_cache_assertions.sv
`timescale 1ns/10ps

module data_cache_assertions (
    input logic clk,
    input logic reset_n,
    input logic mem_read,
    input logic mem_write,
    input logic mem_ready,
    input logic mem_ack,
    input logic cpu_ready,
    input logic cpu_ack
);

    // only one memory request at a time
    mem_one_request: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high together");

    cpu_one_answer: assert property (@(posedge clk) disable iff (!reset_n)
        !(cpu_ready && cpu_ack))
        else $error("cpu_ready and cpu_ack are high together");

    // a request stays up until memory answers it
    read_held: assert property (@(posedge clk) disable iff (!reset_n)
        mem_read && !mem_ready |=> mem_read)
        else $error("mem_read dropped before mem_ready");

    write_held: assert property (@(posedge clk) disable iff (!reset_n)
        mem_write && !mem_ack |=> mem_write)
        else $error("mem_write dropped before mem_ack");

endmodule

bind data_cache data_cache_assertions assertions_i (
    .clk(clk),
    .reset_n(reset_n),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_ready(mem_ready),
    .mem_ack(mem_ack),
    .cpu_ready(cpu_ready),
    .cpu_ack(cpu_ack)
);

// File: bench/data_cache_tb.sv
`timescale 1ns/10ps

module data_cache_tb;

    localparam int set_bits  = 1;
    localparam int num_steps = 26;

    typedef struct packed {
        logic             wr;
        cache_pkg::word_t addr;
        cache_pkg::word_t wdata;
        cache_pkg::word_t exp_rdata;
        logic             miss;
        logic             wb;
        cache_pkg::word_t wb_addr;
    } step_t;

    logic             clk;
    logic             reset_n;
    logic             cpu_valid;
    logic             cpu_write;
    cache_pkg::word_t cpu_addr;
    cache_pkg::word_t cpu_wdata;
    cache_pkg::word_t cpu_rdata;
    logic             cpu_ready;
    logic             cpu_ack;
    logic             mem_read;
    logic             mem_write;
    cache_pkg::word_t mem_addr;
    cache_pkg::line_t mem_wdata;
    cache_pkg::line_t mem_rdata;
    logic             mem_ready;
    logic             mem_ack;

    int word_errs = 0;
    int line_errs = 0;
    int flag_errs = 0;

    // one entry per request answered by the memory model
    logic             ev_write [$];
    cache_pkg::word_t ev_addr  [$];
    cache_pkg::line_t ev_line  [$];

    // memory model contents and the words the cpu has written so far
    cache_pkg::word_t mem_words [cache_pkg::word_t];
    cache_pkg::word_t written   [cache_pkg::word_t];

    // set 0 cycles through lines 0x10, 0x20 and 0x30, set 1 uses line 0x14
    step_t steps [num_steps] = '{
        // wr   addr      wdata     rdata     miss  wb    wb_addr
        '{1'b0, 16'h0011, 16'h0000, 16'h5a4b, 1'b1, 1'b0, 16'h0000},
        '{1'b0, 16'h0013, 16'h0000, 16'h5a49, 1'b0, 1'b0, 16'h0000},
        '{1'b1, 16'h0012, 16'hbeef, 16'h0000, 1'b0, 1'b0, 16'h0000},
        '{1'b0, 16'h0012, 16'h0000, 16'hbeef, 1'b0, 1'b0, 16'h0000},
        '{1'b1, 16'h0021, 16'h1234, 16'h0000, 1'b1, 1'b0, 16'h0000},
        '{1'b0, 16'h0023, 16'h0000, 16'h5a79, 1'b0, 1'b0, 16'h0000},
        '{1'b0, 16'h0021, 16'h0000, 16'h1234, 1'b0, 1'b0, 16'h0000},
        '{1'b0, 16'h0031, 16'h0000, 16'h5a6b, 1'b1, 1'b1, 16'h0010},
        '{1'b0, 16'h0022, 16'h0000, 16'h5a78, 1'b0, 1'b0, 16'h0000},
        '{1'b0, 16'h0010, 16'h0000, 16'h5a4a, 1'b1, 1'b0, 16'h0000},
        '{1'b0, 16'h0012, 16'h0000, 16'hbeef, 1'b0, 1'b0, 16'h0000},
        '{1'b0, 16'h0033, 16'h0000, 16'h5a69, 1'b1, 1'b1, 16'h0020},
        '{1'b0, 16'h0011, 16'h0000, 16'h5a4b, 1'b0, 1'b0, 16'h0000},
        '{1'b0, 16'h0020, 16'h0000, 16'h5a7a, 1'b1, 1'b0, 16'h0000},
        '{1'b0, 16'h0021, 16'h0000, 16'h1234, 1'b0, 1'b0, 16'h0000},
        '{1'b1, 16'h0016, 16'hcafe, 16'h0000, 1'b1, 1'b0, 16'h0000},
        '{1'b0, 16'h0016, 16'h0000, 16'hcafe, 1'b0, 1'b0, 16'h0000},
        '{1'b0, 16'h0014, 16'h0000, 16'h5a4e, 1'b0, 1'b0, 16'h0000},
        '{1'b1, 16'h0032, 16'h7777, 16'h0000, 1'b1, 1'b0, 16'h0000},
        '{1'b0, 16'h0032, 16'h0000, 16'h7777, 1'b0, 1'b0, 16'h0000},
        '{1'b0, 16'h0030, 16'h0000, 16'h5a6a, 1'b0, 1'b0, 16'h0000},
        '{1'b1, 16'h0013, 16'h4444, 16'h0000, 1'b1, 1'b0, 16'h0000},
        '{1'b1, 16'h0022, 16'h5555, 16'h0000, 1'b1, 1'b1, 16'h0030},
        '{1'b0, 16'h0013, 16'h0000, 16'h4444, 1'b0, 1'b0, 16'h0000},
        '{1'b0, 16'h0012, 16'h0000, 16'hbeef, 1'b0, 1'b0, 16'h0000},
        '{1'b0, 16'h0022, 16'h0000, 16'h5555, 1'b0, 1'b0, 16'h0000}
    };

    tb_clock_gen clock_i (
        .clk(clk),
        .reset_n(reset_n)
    );

    data_cache #(
        .set_bits(set_bits)
    ) dut_i (
        .clk(clk),
        .reset_n(reset_n),
        .cpu_valid(cpu_valid),
        .cpu_write(cpu_write),
        .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata),
        .cpu_rdata(cpu_rdata),
        .cpu_ready(cpu_ready),
        .cpu_ack(cpu_ack),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .mem_ack(mem_ack)
    );

    task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            word_errs++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_line(input cache_pkg::line_t got, input cache_pkg::line_t exp,
                              input string what);
        if (got.flat !== exp.flat) begin
            line_errs++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got.flat, exp.flat);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errs++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // unwritten words read back as their address xor 16'h5a5a
    function automatic cache_pkg::line_t fetch_line(input cache_pkg::word_t base);
        cache_pkg::line_t line;
        cache_pkg::word_t a;
        for (int i = 0; i < cache_pkg::words_per_line; i++) begin
            a = base + cache_pkg::word_t'(i);
            line.words[i] = mem_words.exists(a) ? mem_words[a] : (a ^ 16'h5a5a);
        end
        return line;
    endfunction

    task automatic store_line(input cache_pkg::word_t base, input cache_pkg::line_t line);
        for (int i = 0; i < cache_pkg::words_per_line; i++) begin
            mem_words[base + cache_pkg::word_t'(i)] = line.words[i];
        end
    endtask

    // line as the cpu should see it, built from its own writes
    function automatic cache_pkg::line_t expected_line(input cache_pkg::word_t base);
        cache_pkg::line_t line;
        cache_pkg::word_t a;
        for (int i = 0; i < cache_pkg::words_per_line; i++) begin
            a = base + cache_pkg::word_t'(i);
            line.words[i] = written.exists(a) ? written[a] : (a ^ 16'h5a5a);
        end
        return line;
    endfunction

    task automatic report_counts();
        $display("errors: word %0d, line %0d, flag %0d", word_errs, line_errs, flag_errs);
    endtask

    task automatic end_with_failure(input string why);
        $display("%s", why);
        report_counts();
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic check_step(input int idx, input step_t s);
        int    exp_reqs;
        int    last;
        string tag;
        exp_reqs = int'(s.miss) + int'(s.wb);
        last     = exp_reqs - 1;
        tag      = $sformatf("step %0d addr %h", idx, s.addr);
        check_flag(cpu_ack, s.wr, {tag, " cpu_ack"});
        check_flag(cpu_ready, !s.wr, {tag, " cpu_ready"});
        if (!s.wr) begin
            check_word(cpu_rdata, s.exp_rdata, {tag, " cpu_rdata"});
        end
        check_flag(ev_write.size() == exp_reqs, 1'b1, {tag, " memory request count"});
        if (ev_write.size() == exp_reqs) begin
            // the dirty victim must leave before the refill
            if (s.wb) begin
                check_flag(ev_write[0], 1'b1, {tag, " write-back first"});
                check_word(ev_addr[0], s.wb_addr, {tag, " write-back address"});
                check_line(ev_line[0], expected_line(s.wb_addr), {tag, " write-back line"});
            end
            if (s.miss) begin
                check_flag(ev_write[last], 1'b0, {tag, " refill is a read"});
                check_word(ev_addr[last], s.addr & 16'hfffc, {tag, " refill address"});
            end
        end
    endtask

    // memory model answers every request three cycles after it rises
    initial begin
        int   wait_cnt;
        logic pulse;
        wait_cnt = 0;
        pulse    = 1'b0;
        mem_ready <= 1'b0;
        mem_ack   <= 1'b0;
        mem_rdata <= '0;
        forever begin
            @(negedge clk);
            if (pulse || !reset_n) begin
                mem_ready <= 1'b0;
                mem_ack   <= 1'b0;
                pulse    = 1'b0;
                // a refill raised together with the end of a write-back already counts
                wait_cnt = (reset_n && mem_read) ? 1 : 0;
            end else if (mem_read && mem_write) begin
                end_with_failure("memory model saw mem_read and mem_write high together");
            end else if (mem_read || mem_write) begin
                wait_cnt++;
                if (wait_cnt == 3) begin
                    pulse = 1'b1;
                    ev_write.push_back(mem_write);
                    ev_addr.push_back(mem_addr);
                    ev_line.push_back(mem_wdata);
                    if (mem_write) begin
                        store_line(mem_addr, mem_wdata);
                        mem_ack <= 1'b1;
                    end else begin
                        mem_rdata <= fetch_line(mem_addr);
                        mem_ready <= 1'b1;
                    end
                end
            end
        end
    end

    initial begin
        repeat (num_steps * 30) @(posedge clk);
        end_with_failure("timeout: the cache stopped answering requests");
    end

    initial begin
        step_t s;
        cpu_valid <= 1'b0;
        cpu_write <= 1'b0;
        cpu_addr  <= '0;
        cpu_wdata <= '0;
        wait (reset_n === 1'b1);
        @(negedge clk);
        check_flag(mem_read, 1'b0, "mem_read after reset");
        check_flag(mem_write, 1'b0, "mem_write after reset");
        check_flag(cpu_ready, 1'b0, "cpu_ready after reset");
        check_flag(cpu_ack, 1'b0, "cpu_ack after reset");
        for (int i = 0; i < num_steps; i++) begin
            s = steps[i];
            ev_write.delete();
            ev_addr.delete();
            ev_line.delete();
            cpu_valid <= 1'b1;
            cpu_write <= s.wr;
            cpu_addr  <= s.addr;
            cpu_wdata <= s.wdata;
            // outputs are read on the falling edge, where they have settled
            @(negedge clk);
            while (!(cpu_ready || cpu_ack)) @(negedge clk);
            check_step(i, s);
            if (s.wr) begin
                written[s.addr] = s.wdata;
            end
        end
        cpu_valid <= 1'b0;
        @(negedge clk);
        report_counts();
        if (word_errs + line_errs + flag_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset is released on a falling edge like every other driven input
    initial begin
        reset_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset_n <= 1'b1;
    end

endmodule

// File: run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module data_cache_tb -Mdir obj_dir -f tb.f

./obj_dir/Vdata_cache_tb | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

// File: tb.f
verilog/cache_pkg.sv
verilog/cache_tag_store.sv
verilog/cache_line_store.sv
verilog/cache_ctrl.sv
verilog/data_cache.sv
bench/tb_clock_gen.sv
bench/data_cache_assertions.sv
bench/data_cache_tb.sv

// File: verilog/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl #(
    parameter int set_bits = 1,
    localparam int tag_w = cache_pkg::word_w - cache_pkg::offset_w - set_bits
) (
    input  logic                clk,
    input  logic                reset_n,
    // cpu side
    input  logic                cpu_valid,
    input  logic                cpu_write,
    input  cache_pkg::word_t    cpu_addr,
    input  cache_pkg::word_t    cpu_wdata,
    output cache_pkg::word_t    cpu_rdata,
    output logic                cpu_ready,
    output logic                cpu_ack,
    // memory side
    output logic                mem_read,
    output logic                mem_write,
    output cache_pkg::word_t    mem_addr,
    output cache_pkg::line_t    mem_wdata,
    input  cache_pkg::line_t    mem_rdata,
    input  logic                mem_ready,
    input  logic                mem_ack,
    // tag store
    output logic [set_bits-1:0] index,
    output logic [tag_w-1:0]    lookup_tag,
    input  logic                hit,
    input  logic                hit_way,
    input  logic                victim_way,
    input  logic                victim_dirty,
    input  logic [tag_w-1:0]    victim_tag,
    output logic                tag_update,
    output logic                tag_way,
    output logic                tag_fill,
    output logic                tag_dirty,
    // line store
    output logic                line_way,
    output logic                line_we,
    output cache_pkg::line_t    line_wdata,
    input  cache_pkg::line_t    line_rdata
);

    localparam logic [1:0] CHECK      = 2'd0;
    localparam logic [1:0] WRITE_BACK = 2'd1;
    localparam logic [1:0] ALLOCATE   = 2'd2;

    logic [1:0]                    state;
    logic [cache_pkg::offset_w-1:0] word_sel;
    logic                          hit_access;
    logic                          miss;
    logic                          fill;
    logic                          done;
    cache_pkg::word_t              refill_addr;
    cache_pkg::word_t              wb_addr;
    cache_pkg::line_t              src_line;
    cache_pkg::line_t              merged_line;

    // address split
    assign word_sel   = cpu_addr[cache_pkg::offset_w-1:0];
    assign index      = cpu_addr[cache_pkg::offset_w +: set_bits];
    assign lookup_tag = cpu_addr[cache_pkg::word_w-1 -: tag_w];

    assign refill_addr = {cpu_addr[cache_pkg::word_w-1:cache_pkg::offset_w],
                          {cache_pkg::offset_w{1'b0}}};
    assign wb_addr     = {victim_tag, index, {cache_pkg::offset_w{1'b0}}};

    assign hit_access = (state == CHECK) && cpu_valid && hit;
    assign miss       = (state == CHECK) && cpu_valid && !hit;
    assign fill       = (state == ALLOCATE) && mem_ready;
    assign done       = hit_access || fill;

    // refill data comes straight from memory, hits from the stored line
    always_comb begin
        src_line    = (state == ALLOCATE) ? mem_rdata : line_rdata;
        merged_line = src_line;
        merged_line.words[word_sel] = cpu_wdata;
    end

    assign cpu_rdata = src_line.words[word_sel];
    assign cpu_ready = done && !cpu_write;
    assign cpu_ack   = done && cpu_write;

    // a miss always replaces the lru way
    assign line_way   = hit ? hit_way : victim_way;
    assign line_we    = (hit_access && cpu_write) || fill;
    assign line_wdata = cpu_write ? merged_line : src_line;

    assign tag_update = done;
    assign tag_way    = line_way;
    assign tag_fill   = (state == ALLOCATE);
    assign tag_dirty  = cpu_write;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= CHECK;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            case (state)
                CHECK: begin
                    if (miss && victim_dirty) begin
                        mem_write <= 1'b1;
                        state     <= WRITE_BACK;
                    end else if (miss) begin
                        mem_read <= 1'b1;
                        state    <= ALLOCATE;
                    end
                end
                WRITE_BACK: begin
                    // victim is out, fetch the requested line next
                    if (mem_ack) begin
                        mem_write <= 1'b0;
                        mem_read  <= 1'b1;
                        state     <= ALLOCATE;
                    end
                end
                ALLOCATE: begin
                    if (mem_ready) begin
                        mem_read <= 1'b0;
                        state    <= CHECK;
                    end
                end
                default: begin
                    state <= CHECK;
                end
            endcase
        end
    end

    // request address and write-back line
    always_ff @(posedge clk) begin
        if (miss) begin
            mem_addr  <= victim_dirty ? wb_addr : refill_addr;
            mem_wdata <= line_rdata;
        end else if ((state == WRITE_BACK) && mem_ack) begin
            mem_addr <= refill_addr;
        end
    end

endmodule

// File: verilog/cache_line_store.sv
`timescale 1ns/10ps

module cache_line_store #(
    parameter int set_bits = 1
) (
    input  logic                clk,
    input  logic [set_bits-1:0] index,
    input  logic                line_way,
    input  logic                line_we,
    input  cache_pkg::line_t    line_wdata,
    output cache_pkg::line_t    line_rdata
);

    localparam int num_sets = 1 << set_bits;

    // one line per way per set
    cache_pkg::line_t lines [num_sets][cache_pkg::num_ways];

    // read path is combinational so hits answer in the same cycle
    assign line_rdata = lines[index][line_way];

    always_ff @(posedge clk) begin
        if (line_we) begin
            lines[index][line_way] <= line_wdata;
        end
    end

endmodule

// File: verilog/cache_pkg.sv
package cache_pkg;

    // cpu word and address width
    parameter int word_w = 16;

    // words held by one cache line
    parameter int words_per_line = 4;

    // address bits that pick a word inside a line
    parameter int offset_w = 2;

    // associativity, fixed by the single lru bit per set
    parameter int num_ways = 2;

    // one cpu data word or address
    typedef logic [word_w-1:0] word_t;

    // a cache line seen two ways:
    // flat block as memory transfers it, or an array of words for the cpu
    // word 0 sits in the lowest bits
    typedef union packed {
        logic [words_per_line*word_w-1:0] flat;
        word_t [words_per_line-1:0]       words;
    } line_t;

endpackage

// File: verilog/cache_tag_store.sv
`timescale 1ns/10ps

module cache_tag_store #(
    parameter int set_bits = 1,
    localparam int tag_w = cache_pkg::word_w - cache_pkg::offset_w - set_bits
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic [set_bits-1:0] index,
    input  logic [tag_w-1:0]    lookup_tag,
    input  logic                tag_update,
    input  logic                tag_way,
    input  logic                tag_fill,
    input  logic                tag_dirty,
    output logic                hit,
    output logic                hit_way,
    output logic                victim_way,
    output logic                victim_dirty,
    output logic [tag_w-1:0]    victim_tag
);

    localparam int num_sets = 1 << set_bits;

    logic [tag_w-1:0]                tags  [num_sets][cache_pkg::num_ways];
    logic [cache_pkg::num_ways-1:0]  valid [num_sets];
    logic [cache_pkg::num_ways-1:0]  dirty [num_sets];
    // lru bit names the way to evict next
    logic [num_sets-1:0]             lru;
    logic [cache_pkg::num_ways-1:0]  match;

    always_comb begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            match[w] = valid[index][w] && (tags[index][w] == lookup_tag);
        end
    end

    assign hit          = |match;
    assign hit_way      = match[1];
    assign victim_way   = lru[index];
    assign victim_dirty = valid[index][victim_way] && dirty[index][victim_way];
    assign victim_tag   = tags[index][victim_way];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            lru <= '0;
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else if (tag_update) begin
            if (tag_fill) begin
                valid[index][tag_way] <= 1'b1;
                dirty[index][tag_way] <= tag_dirty;
            end else begin
                dirty[index][tag_way] <= dirty[index][tag_way] | tag_dirty;
            end
            // the other way becomes least recently used
            lru[index] <= ~tag_way;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_update && tag_fill) begin
            tags[index][tag_way] <= lookup_tag;
        end
    end

endmodule

// File: verilog/data_cache.sv
`timescale 1ns/10ps

module data_cache #(
    parameter int set_bits = 1
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             cpu_valid,
    input  logic             cpu_write,
    input  cache_pkg::word_t cpu_addr,
    input  cache_pkg::word_t cpu_wdata,
    output cache_pkg::word_t cpu_rdata,
    output logic             cpu_ready,
    output logic             cpu_ack,
    output logic             mem_read,
    output logic             mem_write,
    output cache_pkg::word_t mem_addr,
    output cache_pkg::line_t mem_wdata,
    input  cache_pkg::line_t mem_rdata,
    input  logic             mem_ready,
    input  logic             mem_ack
);

    localparam int tag_w = cache_pkg::word_w - cache_pkg::offset_w - set_bits;

    logic [set_bits-1:0] index;
    logic [tag_w-1:0]    lookup_tag;
    logic [tag_w-1:0]    victim_tag;
    logic                hit;
    logic                hit_way;
    logic                victim_way;
    logic                victim_dirty;
    logic                tag_update;
    logic                tag_way;
    logic                tag_fill;
    logic                tag_dirty;
    logic                line_way;
    logic                line_we;
    cache_pkg::line_t    line_wdata;
    cache_pkg::line_t    line_rdata;

    cache_ctrl #(
        .set_bits(set_bits)
    ) ctrl_i (
        .clk(clk),
        .reset_n(reset_n),
        .cpu_valid(cpu_valid),
        .cpu_write(cpu_write),
        .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata),
        .cpu_rdata(cpu_rdata),
        .cpu_ready(cpu_ready),
        .cpu_ack(cpu_ack),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .mem_ack(mem_ack),
        .index(index),
        .lookup_tag(lookup_tag),
        .hit(hit),
        .hit_way(hit_way),
        .victim_way(victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag(victim_tag),
        .tag_update(tag_update),
        .tag_way(tag_way),
        .tag_fill(tag_fill),
        .tag_dirty(tag_dirty),
        .line_way(line_way),
        .line_we(line_we),
        .line_wdata(line_wdata),
        .line_rdata(line_rdata)
    );

    cache_tag_store #(
        .set_bits(set_bits)
    ) tag_store_i (
        .clk(clk),
        .reset_n(reset_n),
        .index(index),
        .lookup_tag(lookup_tag),
        .tag_update(tag_update),
        .tag_way(tag_way),
        .tag_fill(tag_fill),
        .tag_dirty(tag_dirty),
        .hit(hit),
        .hit_way(hit_way),
        .victim_way(victim_way),
        .victim_dirty(victim_dirty),
        .victim_tag(victim_tag)
    );

    cache_line_store #(
        .set_bits(set_bits)
    ) line_store_i (
        .clk(clk),
        .index(index),
        .line_way(line_way),
        .line_we(line_we),
        .line_wdata(line_wdata),
        .line_rdata(line_rdata)
    );

endmodule
